// File: files.f
+incdir+include
verilog/pcs_block_pkg.sv
verilog/am_lock_pkg.sv
verilog/am_block_capture.sv
verilog/am_marker_compare.sv
verilog/am_lock_fsm.sv
verilog/am_lock_output.sv
verilog/am_lock_top.sv
verif/tb_clock_gen.sv
verif/am_lock_checker.sv
verif/am_lock_tb.sv

// File: include/am_defines.svh
// ----------------------------------------------------------
// alignment marker lock constants
// block and marker widths, lane count, period, thresholds
// ----------------------------------------------------------
`ifndef AM_DEFINES_SVH
`define AM_DEFINES_SVH

`define AM_BLOCK_LEN       66     // sync header + 64b payload
`define AM_MARKER_LEN      48     // M0..M2 and M4..M6, bip bytes skipped
`define AM_N_LANES         20     // pcs lanes, one marker each

// valid blocks from one marker to the next
`define AM_PERIOD_DEFAULT  16384

// lock hysteresis
`define AM_GOOD_TO_LOCK    2      // good in a row, finding one included
`define AM_BAD_TO_UNLOCK   4      // bad in a row while locked

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the marker lock testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
	-f files.f --top-module am_lock_tb -o am_lock_sim

./obj_dir/am_lock_sim > sim.log
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	exit 0
else
	exit 1
fi

// File: verif/am_lock_checker.sv
// ----------------------------------------------------------
// follows the lane output block by block against the input,
// counts flags, compares lock, lane and counts per scenario
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module am_lock_checker
(
	input  wire                         i_clock,
	input  wire                         i_reset,
	input  wire                         i_in_valid,    // dut input stream
	input  pcs_block_pkg::coded_block_t i_in_block,
	input  am_lock_pkg::am_lane_out_t   i_lane,
	input  wire                         i_check,       // end of scenario strobe
	input  wire [127:0]                 i_name,
	input  wire                         i_exp_lock,
	input  am_lock_pkg::lane_id_t       i_exp_lane,
	input  wire [15:0]                  i_exp_flags,
	input  wire [15:0]                  i_exp_valid,   // valid blocks sent
	output int                          o_pass_count,
	output int                          o_fail_count
);

	import pcs_block_pkg::*;

	localparam int lp_latency = 4;   // block in at t, seen on o_lane at t+4

	logic [15:0]           flag_cnt;
	logic [15:0]           valid_cnt;
	logic [15:0]           stray_flag_cnt;   // flags on data-header blocks
	logic [15:0]           stream_err_cnt;   // output blocks off the input stream
	logic [lp_latency-1:0] exp_valid_q;      // input stream delayed to the output
	coded_block_t          exp_block_q [lp_latency];
	int                    pass_cnt = 0;
	int                    fail_cnt = 0;

	task automatic check_scenario;
		int errors;
		errors = 0;
		if (i_lane.lock !== i_exp_lock)
		begin
			$display("MISMATCH %s lock expected %0d actual %0d", i_name, i_exp_lock, i_lane.lock);
			errors++;
		end
		if (i_lane.lane !== i_exp_lane)
		begin
			$display("MISMATCH %s lane expected %0d actual %0d", i_name, i_exp_lane, i_lane.lane);
			errors++;
		end
		if (flag_cnt !== i_exp_flags)
		begin
			$display("MISMATCH %s flags expected %0d actual %0d", i_name, i_exp_flags, flag_cnt);
			errors++;
		end
		if (valid_cnt !== i_exp_valid)
		begin
			$display("MISMATCH %s valid blocks expected %0d actual %0d",
				i_name, i_exp_valid, valid_cnt);
			errors++;
		end
		if (stray_flag_cnt != 16'd0)
		begin
			$display("ERROR %s marker flag raised on a block without a control header", i_name);
			errors++;
		end
		if (stream_err_cnt != 16'd0)
		begin
			$display("ERROR %s %0d output blocks out of step with the input stream",
				i_name, stream_err_cnt);
			errors++;
		end
		if (errors == 0)
		begin
			$display("ok %s lock %0d lane %0d flags %0d", i_name, i_lane.lock, i_lane.lane, flag_cnt);
			pass_cnt <= pass_cnt + 1;
		end
		else
			fail_cnt <= fail_cnt + 1;
	endtask

	always @(posedge i_clock)
	begin
		if (i_reset)
		begin
			flag_cnt       <= '0;   // counts are per scenario
			valid_cnt      <= '0;
			stray_flag_cnt <= '0;
			stream_err_cnt <= '0;
			exp_valid_q    <= '0;
		end
		else
		begin
			exp_valid_q    <= {exp_valid_q[lp_latency-2:0], i_in_valid};
			exp_block_q[0] <= i_in_block;
			for (int i = 1; i < lp_latency; i++)
				exp_block_q[i] <= exp_block_q[i-1];
			// same blocks, same order, fixed latency
			if ((i_lane.valid !== exp_valid_q[lp_latency-1]) ||
				(exp_valid_q[lp_latency-1] && (i_lane.block !== exp_block_q[lp_latency-1])))
			begin
				$display("MISMATCH %s block expected %0d %h actual %0d %h", i_name,
					exp_valid_q[lp_latency-1], exp_block_q[lp_latency-1],
					i_lane.valid, i_lane.block);
				stream_err_cnt <= stream_err_cnt + 16'd1;
			end
			if (i_lane.valid)
				valid_cnt <= valid_cnt + 16'd1;
			if (i_lane.am_flag)
			begin
				flag_cnt <= flag_cnt + 16'd1;
				if (i_lane.block.sh != SH_CTRL)
					stray_flag_cnt <= stray_flag_cnt + 16'd1;
			end
			if (i_check)
				check_scenario();   // pipeline drained by now
		end
	end

	assign o_pass_count = pass_cnt;
	assign o_fail_count = fail_cnt;

endmodule

`default_nettype wire

// File: verif/am_lock_tb.sv
// ----------------------------------------------------------
// marker lock testbench: scenario table driven through the
// DUT one after another, each after a reset
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "am_defines.svh"

module am_lock_tb;

	import pcs_block_pkg::*;
	import am_lock_pkg::*;

	localparam int lp_period = 32;   // marker period under test
	localparam int lp_clk_ns = 40;
	localparam int lp_drain  = 8;    // idle cycles to empty the pipe

	typedef struct packed {
		logic [127:0] name;
		lane_id_t     lane;
		logic [7:0]   periods;
		logic [15:0]  bad;          // bit n set, marker of period n is bad
		logic         bad_hdr;      // markers go out with a data header
		logic         wrong_lane;   // bad marker is the next lane's marker
		logic         idle;         // invalid cycles mixed into fillers
		logic         exp_lock;
		lane_id_t     exp_lane;
		logic [15:0]  exp_flags;
	} scenario_t;

	scenario_t    scenarios_q [$];
	logic         clock;
	logic         reset;
	logic         restart;
	logic         valid;
	coded_block_t block;
	am_lane_out_t lane_out;
	logic         check;
	logic [127:0] chk_name;
	logic         chk_lock;
	lane_id_t     chk_lane;
	logic [15:0]  chk_flags;
	logic [15:0]  chk_valid;
	int           pass_count;
	int           fail_count;
	int           seed = 32'h599ff492;
	longint       wd_limit;
	logic         wd_armed = 1'b0;

	tb_clock_gen u_clock_gen
	(
		.i_restart (restart),
		.o_clock   (clock),
		.o_reset   (reset)
	);

	am_lock_top
	#(
		.p_am_period (lp_period)
	)
	u_am_lock_top
	(
		.i_clock (clock),
		.i_reset (reset),
		.i_valid (valid),
		.i_block (block),
		.o_lane  (lane_out)
	);

	am_lock_checker u_checker
	(
		.i_clock      (clock),
		.i_reset      (reset),
		.i_in_valid   (valid),
		.i_in_block   (block),
		.i_lane       (lane_out),
		.i_check      (check),
		.i_name       (chk_name),
		.i_exp_lock   (chk_lock),
		.i_exp_lane   (chk_lane),
		.i_exp_flags  (chk_flags),
		.i_exp_valid  (chk_valid),
		.o_pass_count (pass_count),
		.o_fail_count (fail_count)
	);

	function automatic void add_scenario(logic [127:0] name, lane_id_t lane, logic [7:0] periods,
		logic [15:0] bad, logic bad_hdr, logic wrong_lane, logic idle, logic exp_lock,
		lane_id_t exp_lane, logic [15:0] exp_flags);
		scenario_t sc;
		sc.name       = name;
		sc.lane       = lane;
		sc.periods    = periods;
		sc.bad        = bad;
		sc.bad_hdr    = bad_hdr;
		sc.wrong_lane = wrong_lane;
		sc.idle       = idle;
		sc.exp_lock   = exp_lock;
		sc.exp_lane   = exp_lane;
		sc.exp_flags  = exp_flags;
		scenarios_q.push_back(sc);
	endfunction

	// data-header block, payload kept off every marker value
	function automatic coded_block_t make_filler();
		coded_block_t b;
		am_value_t    v;
		b.sh          = SH_DATA;
		b.payload.raw = {$random(seed), $random(seed)};
		v = {b.payload.am.m0, b.payload.am.m1, b.payload.am.m2,
			b.payload.am.m4, b.payload.am.m5, b.payload.am.m6};
		for (int i = 0; i < `AM_N_LANES; i++)
		begin
			if (v == AM_MARKERS[i])
				b.payload.am.m6 = ~b.payload.am.m6;
		end
		return b;
	endfunction

	function automatic coded_block_t make_marker(lane_id_t l, logic corrupt, logic data_hdr);
		coded_block_t b;
		am_value_t    v;
		v = AM_MARKERS[l];
		if (corrupt)
			v = v ^ 48'h0000_0100_0000;   // one bit off in M2
		b.sh              = data_hdr ? SH_DATA : SH_CTRL;
		b.payload.am.m0   = v[47:40];
		b.payload.am.m1   = v[39:32];
		b.payload.am.m2   = v[31:24];
		b.payload.am.bip3 = 8'hA5;   // bip not checked
		b.payload.am.m4   = v[23:16];
		b.payload.am.m5   = v[15:8];
		b.payload.am.m6   = v[7:0];
		b.payload.am.bip7 = 8'h5A;
		return b;
	endfunction

	task automatic send(logic v, coded_block_t b);
		valid <= v;
		block <= b;
		@(posedge clock);
	endtask

	task automatic apply_reset();
		valid   <= 1'b0;
		restart <= 1'b1;
		@(posedge clock);
		restart <= 1'b0;
		@(posedge clock);
		while (reset)
			@(posedge clock);
	endtask

	task automatic run_scenario(scenario_t sc);
		lane_id_t    other_lane;
		logic [15:0] bad_bits;
		if (sc.lane == lane_id_t'(`AM_N_LANES - 1))
			other_lane = '0;
		else
			other_lane = sc.lane + 5'd1;
		bad_bits = sc.bad;
		chk_name <= sc.name;   // names stream mismatches as they happen
		apply_reset();
		for (int p = 0; p < int'(sc.periods); p++)
		begin
			if (bad_bits[0] && sc.wrong_lane)
				send(1'b1, make_marker(other_lane, 1'b0, sc.bad_hdr));
			else
				send(1'b1, make_marker(sc.lane, bad_bits[0], sc.bad_hdr));
			bad_bits = bad_bits >> 1;
			for (int j = 1; j < lp_period; j++)
			begin
				if (sc.idle && (j % 5 == 0))
					send(1'b0, make_marker(sc.lane, 1'b0, 1'b0));   // marker on an idle slot
				send(1'b1, make_filler());
			end
		end
		repeat (lp_drain)
			send(1'b0, make_filler());
		check     <= 1'b1;
		chk_lock  <= sc.exp_lock;
		chk_lane  <= sc.exp_lane;
		chk_flags <= sc.exp_flags;
		chk_valid <= 16'(int'(sc.periods) * lp_period);
		@(posedge clock);
		check <= 1'b0;
	endtask

	initial
	begin
		longint cycles;
		restart   = 1'b0;
		valid     = 1'b0;
		block     = '0;
		check     = 1'b0;
		chk_name  = '0;
		chk_lock  = 1'b0;
		chk_lane  = '0;
		chk_flags = '0;
		chk_valid = '0;
		//           name              lane   per    bad       hdr   wl    idle  lock  lane   flags
		add_scenario("clean_lane7",    5'd7,  8'd4, 16'h0000, 1'b0, 1'b0, 1'b0, 1'b1, 5'd7,  16'd4);
		add_scenario("data_header",    5'd3,  8'd3, 16'h0000, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0,  16'd0);
		add_scenario("one_bad_locked", 5'd12, 8'd6, 16'h0008, 1'b0, 1'b0, 1'b0, 1'b1, 5'd12, 16'd5);
		add_scenario("unlock_relock",  5'd5,  8'd9, 16'h003C, 1'b0, 1'b0, 1'b0, 1'b1, 5'd5,  16'd5);
		add_scenario("unlock_verify",  5'd14, 8'd7, 16'h003C, 1'b0, 1'b0, 1'b0, 1'b0, 5'd14, 16'd3);
		add_scenario("wrong_lane",     5'd9,  8'd5, 16'h0004, 1'b0, 1'b1, 1'b0, 1'b1, 5'd9,  16'd4);
		add_scenario("lane0_idle",     5'd0,  8'd4, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 5'd0,  16'd4);
		add_scenario("lane19_idle",    5'd19, 8'd4, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1, 5'd19, 16'd4);
		cycles = 0;
		foreach (scenarios_q[i])
			cycles += longint'(scenarios_q[i].periods) * lp_period * 2 + 40;   // idles, reset, drain
		wd_limit = cycles * lp_clk_ns + 5000;
		wd_armed = 1'b1;
		@(posedge clock);
		foreach (scenarios_q[i])
			run_scenario(scenarios_q[i]);
		repeat (2)
			@(posedge clock);
		$display("scenarios passed %0d failed %0d", pass_count, fail_count);
		if (fail_count == 0 && pass_count == scenarios_q.size())
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		wait (wd_armed);
		#(wd_limit);
		$display("watchdog expired, run still going after %0d ns", wd_limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// ----------------------------------------------------------
// testbench clock, 40 ns period, and 10-cycle reset
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
	parameter int p_half_period  = 20,
	parameter int p_reset_cycles = 10
)
(
	input  wire  i_restart,   // one-cycle request for a fresh reset
	output logic o_clock,
	output logic o_reset
);

	int reset_left = p_reset_cycles;   // reset is on from time zero

	initial
	begin
		o_clock = 1'b0;
		forever #(p_half_period) o_clock = ~o_clock;
	end

	always @(posedge o_clock)
	begin
		if (i_restart)
			reset_left <= p_reset_cycles;
		else if (reset_left != 0)
			reset_left <= reset_left - 1;
	end

	assign o_reset = (reset_left != 0);   // high for p_reset_cycles edges

endmodule

`default_nettype wire

// File: verilog/am_block_capture.sv
// ----------------------------------------------------------
// input register, tags control-header blocks as candidates
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module am_block_capture
(
	input  wire                          i_clock,
	input  wire                          i_reset,
	input  wire                          i_valid,
	input  pcs_block_pkg::coded_block_t  i_block,
	output am_lock_pkg::am_match_t       o_cand
);

	import pcs_block_pkg::*;

	logic         cand_valid;
	logic         cand_flag;
	coded_block_t cand_block;

	// control state
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			cand_valid <= 1'b0;
			cand_flag  <= 1'b0;
		end
		else
		begin
			cand_valid <= i_valid;
			cand_flag  <= i_valid && (i_block.sh == SH_CTRL);   // data header never a marker
		end
	end

	// payload, taken every cycle
	always_ff @(posedge i_clock)
	begin
		cand_block <= i_block;
	end

	always_comb
	begin
		o_cand.valid     = cand_valid;
		o_cand.candidate = cand_flag;
		o_cand.hit       = 1'b0;   // filled in by compare
		o_cand.lane      = '0;
		o_cand.block     = cand_block;
	end

endmodule

`default_nettype wire

// File: verilog/am_lock_fsm.sv
// ----------------------------------------------------------
// marker lock machine: period counter, good/bad counts,
// find/verify/locked states and search mask
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "am_defines.svh"

module am_lock_fsm
#(
	parameter int p_am_period = `AM_PERIOD_DEFAULT
)
(
	input  wire                       i_clock,
	input  wire                       i_reset,
	input  am_lock_pkg::am_match_t    i_match,
	output am_lock_pkg::lane_mask_t   o_search_mask,
	output am_lock_pkg::am_lane_out_t o_out
);

	import am_lock_pkg::*;

	localparam int lp_cnt_w  = $clog2(p_am_period);
	localparam int lp_good_w = $clog2(`AM_GOOD_TO_LOCK + 1);
	localparam int lp_bad_w  = $clog2(`AM_BAD_TO_UNLOCK + 1);
	localparam lane_mask_t lp_mask_all = '1;

	lock_state_t                 state;
	logic [lp_cnt_w-1:0]         period_cnt;   // valid blocks since last marker slot
	logic [lp_good_w-1:0]        good_cnt;
	logic [lp_bad_w-1:0]         bad_cnt;
	lane_id_t                    lane_q;       // lane being tracked
	lane_mask_t                  search_mask;
	logic                        at_expected;
	logic                        out_valid;
	logic                        out_flag;
	logic                        out_lock;
	pcs_block_pkg::coded_block_t out_block;

	// p_am_period valid blocks after the last marker
	assign at_expected = (period_cnt == lp_cnt_w'(p_am_period - 1));

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state       <= FIND;
			search_mask <= lp_mask_all;
			period_cnt  <= '0;
			good_cnt    <= '0;
			bad_cnt     <= '0;
			lane_q      <= '0;
			out_valid   <= 1'b0;
			out_flag    <= 1'b0;
			out_lock    <= 1'b0;
		end
		else
		begin
			out_valid <= i_match.valid;
			out_flag  <= 1'b0;   // pulses only on accepted markers
			if (i_match.valid)   // idle cycles freeze everything
			begin
				period_cnt <= period_cnt + 1'b1;
				case (state)
					FIND:
					begin
						if (i_match.hit)
						begin
							lane_q      <= i_match.lane;
							search_mask <= lane_mask_t'(1) << i_match.lane;   // narrow to this lane
							period_cnt  <= '0;
							good_cnt    <= lp_good_w'(1);   // finding marker counts
							bad_cnt     <= '0;
							out_flag    <= 1'b1;
							state       <= VERIFY;
						end
					end
					VERIFY:
					begin
						if (at_expected)
						begin
							period_cnt <= '0;
							if (i_match.hit)
							begin
								out_flag <= 1'b1;
								if (good_cnt == lp_good_w'(`AM_GOOD_TO_LOCK - 1))
								begin
									state    <= LOCKED;
									bad_cnt  <= '0;
									out_lock <= 1'b1;
								end
								else
									good_cnt <= good_cnt + 1'b1;
							end
							else
							begin
								// marker missing, start over
								state       <= FIND;
								search_mask <= lp_mask_all;
							end
						end
					end
					LOCKED:
					begin
						if (at_expected)
						begin
							period_cnt <= '0;   // keep slot grid even on a miss
							if (i_match.hit)
							begin
								bad_cnt  <= '0;
								out_flag <= 1'b1;
							end
							else if (bad_cnt == lp_bad_w'(`AM_BAD_TO_UNLOCK - 1))
							begin
								state       <= FIND;
								search_mask <= lp_mask_all;
								out_lock    <= 1'b0;
							end
							else
								bad_cnt <= bad_cnt + 1'b1;
						end
					end
					default:
					begin
						state       <= FIND;
						search_mask <= lp_mask_all;
						out_lock    <= 1'b0;
					end
				endcase
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		out_block <= i_match.block;
	end

	assign o_search_mask = search_mask;

	always_comb
	begin
		o_out.valid   = out_valid;
		o_out.block   = out_block;
		o_out.am_flag = out_flag;
		o_out.lock    = out_lock;
		o_out.lane    = lane_q;   // last found lane, kept through unlock
	end

endmodule

`default_nettype wire

// File: verilog/am_lock_output.sv
// ----------------------------------------------------------
// output register for block, marker flag, lock and lane
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module am_lock_output
(
	input  wire                       i_clock,
	input  wire                       i_reset,
	input  am_lock_pkg::am_lane_out_t i_out,
	output am_lock_pkg::am_lane_out_t o_lane
);

	am_lock_pkg::am_lane_out_t lane_q;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			lane_q.valid   <= 1'b0;
			lane_q.am_flag <= 1'b0;
			lane_q.lock    <= 1'b0;
			lane_q.lane    <= '0;
		end
		else
		begin
			lane_q.valid   <= i_out.valid;
			lane_q.am_flag <= i_out.valid && i_out.am_flag;   // no flag on idle cycles
			lane_q.lock    <= i_out.lock;
			lane_q.lane    <= i_out.lane;
		end
	end

	always_ff @(posedge i_clock)
	begin
		lane_q.block <= i_out.block;
	end

	assign o_lane = lane_q;

endmodule

`default_nettype wire

// File: verilog/am_lock_pkg.sv
// ----------------------------------------------------------
// marker lock types, marker table and stage records
// ----------------------------------------------------------
`default_nettype none
`include "am_defines.svh"

package am_lock_pkg;

	typedef logic [4:0]               lane_id_t;
	typedef logic [`AM_N_LANES-1:0]   lane_mask_t;   // bit n = lane n
	typedef logic [`AM_MARKER_LEN-1:0] am_value_t;

	// {M0,M1,M2,M4,M5,M6} per pcs lane
	localparam am_value_t AM_MARKERS [`AM_N_LANES] = '{
		48'hC168213E97DE, 48'h9D718E628E71, 48'h594BE8A6B417, 48'h4D957BB26A84,
		48'hF507090AF8F6, 48'hDD14C222EB3D, 48'h9A4A2665B5D9, 48'h7B456684BA99,
		48'hA024765FDB89, 48'h68C9FB973604, 48'hFD6C99029366, 48'hB99155466EAA,
		48'h5CB9B2A3464D, 48'h1AF8BDE50742, 48'h83C7CA7C3835, 48'h3536CDCAC932,
		48'hC4314C3BCEB3, 48'hADD6B7522948, 48'h5F662AA099D5, 48'hC0F0E53F0F1A
	};

	typedef enum logic [1:0] {
		FIND   = 2'd0,   // any lane accepted
		VERIFY = 2'd1,   // lane picked, waiting on second marker
		LOCKED = 2'd2
	} lock_state_t;

	// capture -> compare -> lock fsm
	typedef struct packed {
		logic                        valid;
		logic                        candidate;   // ctrl header seen
		logic                        hit;
		lane_id_t                    lane;
		pcs_block_pkg::coded_block_t block;
	} am_match_t;

	// lock fsm -> output -> top port
	typedef struct packed {
		logic                        valid;
		pcs_block_pkg::coded_block_t block;
		logic                        am_flag;
		logic                        lock;
		lane_id_t                    lane;
	} am_lane_out_t;

endpackage

`default_nettype wire

// File: verilog/am_lock_top.sv
// ----------------------------------------------------------
// alignment marker lock for one pcs lane
// capture, compare, lock fsm and output register in a row
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "am_defines.svh"

module am_lock_top
#(
	parameter int p_am_period = `AM_PERIOD_DEFAULT
)
(
	input  wire                         i_clock,
	input  wire                         i_reset,
	input  wire                         i_valid,
	input  pcs_block_pkg::coded_block_t i_block,
	output am_lock_pkg::am_lane_out_t   o_lane
);

	am_lock_pkg::am_match_t    cand;          // stage 1 out
	am_lock_pkg::am_match_t    match;         // stage 2 out
	am_lock_pkg::lane_mask_t   search_mask;   // fed back from fsm
	am_lock_pkg::am_lane_out_t fsm_out;       // stage 3 out

	am_block_capture u_capture
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_valid (i_valid),
		.i_block (i_block),
		.o_cand  (cand)
	);

	am_marker_compare u_compare
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_cand        (cand),
		.i_search_mask (search_mask),
		.o_match       (match)
	);

	am_lock_fsm
	#(
		.p_am_period (p_am_period)
	)
	u_lock_fsm
	(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_match       (match),
		.o_search_mask (search_mask),
		.o_out         (fsm_out)
	);

	am_lock_output u_output
	(
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_out   (fsm_out),
		.o_lane  (o_lane)
	);

endmodule

`default_nettype wire

// File: verilog/am_marker_compare.sv
// ----------------------------------------------------------
// compares a candidate block against the masked marker table
// and registers the lowest matching lane
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "am_defines.svh"

module am_marker_compare
(
	input  wire                      i_clock,
	input  wire                      i_reset,
	input  am_lock_pkg::am_match_t   i_cand,
	input  am_lock_pkg::lane_mask_t  i_search_mask,
	output am_lock_pkg::am_match_t   o_match
);

	import am_lock_pkg::*;

	pcs_block_pkg::am_fields_t am_view;
	am_value_t                 am_value;
	lane_mask_t                match_vec;     // one bit per table entry
	logic                      any_match;
	lane_id_t                  match_lane;
	am_match_t                 match_q;

	// marker view of the payload, bip bytes dropped
	assign am_view  = i_cand.block.payload.am;
	assign am_value = {am_view.m0, am_view.m1, am_view.m2,
		am_view.m4, am_view.m5, am_view.m6};

	always_comb
	begin
		for (int i = 0; i < `AM_N_LANES; i++)
		begin
			match_vec[i] = i_search_mask[i] && (am_value == AM_MARKERS[i]);
		end
	end

	// lowest lane wins, walk down so the last write is the lowest
	always_comb
	begin
		match_lane = '0;
		for (int i = `AM_N_LANES - 1; i >= 0; i--)
		begin
			if (match_vec[i])
				match_lane = lane_id_t'(i);
		end
	end

	assign any_match = i_cand.candidate && (|match_vec);   // header gate

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			match_q.valid     <= 1'b0;
			match_q.candidate <= 1'b0;
			match_q.hit       <= 1'b0;
			match_q.lane      <= '0;
		end
		else
		begin
			match_q.valid     <= i_cand.valid;
			match_q.candidate <= i_cand.candidate;
			match_q.hit       <= any_match;
			match_q.lane      <= any_match ? match_lane : '0;
		end
	end

	always_ff @(posedge i_clock)
	begin
		match_q.block <= i_cand.block;   // no reset on payload
	end

	assign o_match = match_q;

endmodule

`default_nettype wire

// File: verilog/pcs_block_pkg.sv
// ----------------------------------------------------------
// 64b/66b coded block types, payload seen as data or marker
// ----------------------------------------------------------
`default_nettype none
`include "am_defines.svh"

package pcs_block_pkg;

	typedef logic [1:0] sync_header_t;

	localparam sync_header_t SH_CTRL = 2'b10;   // control block, markers ride here
	localparam sync_header_t SH_DATA = 2'b01;

	// marker layout, M0 in the top byte
	typedef struct packed {
		logic [7:0] m0;
		logic [7:0] m1;
		logic [7:0] m2;
		logic [7:0] bip3;
		logic [7:0] m4;
		logic [7:0] m5;
		logic [7:0] m6;
		logic [7:0] bip7;
	} am_fields_t;

	typedef union packed {
		logic [`AM_BLOCK_LEN-3:0] raw;   // plain data view
		am_fields_t               am;    // marker view
	} block_payload_u;

	typedef struct packed {
		sync_header_t   sh;        // bits 65:64
		block_payload_u payload;
	} coded_block_t;

endpackage

`default_nettype wire
